//--- flist.f
rtl/roce_pkg.sv
rtl/roce_rx_ctrl.sv
rtl/roce_hdr_parse.sv
rtl/roce_ack_rx.sv
testbench/roce_ack_rx_props.sv
testbench/tb_roce_ack_rx.sv

//--- run.sh
#!/bin/sh
# build and run the roce ack receiver testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_roce_ack_rx \
  -f flist.f \
  -o sim_roce_ack_rx
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build returned status $status"
  exit "$status"
fi

./obj_dir/sim_roce_ack_rx
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation run returned status $status"
  exit "$status"
fi

exit 0

//--- testbench/tb_roce_ack_rx.sv
/* testbench for the roce ack receiver: runs a frame table through the DUT and
   checks the ack record, drop pulses, busy and handshake timing */
`timescale 1ns/1ps

module tb_roce_ack_rx;

  localparam int NUM_ROWS   = 7;
  localparam int MAX_CYCLES = NUM_ROWS * 20;

  localparam logic [7:0]  OP_ACK     = 8'h11;
  localparam logic [7:0]  OP_OTHER   = 8'h0a;
  localparam logic [15:0] PORT_ROCE  = 16'd4791;
  localparam logic [15:0] PORT_OTHER = 16'd4790;

  // expected outcome of a frame
  localparam logic [1:0] OUT_ACCEPT   = 2'd0;
  localparam logic [1:0] OUT_NOT_ACK  = 2'd1;
  localparam logic [1:0] OUT_BAD_ICRC = 2'd2;

  typedef struct packed {
    logic [7:0]  op_code;
    logic [15:0] dest_port;
    logic        icrc_match;
    logic [1:0]  beats;
    logic [3:0]  stalls;
    logic [1:0]  outcome;
  } row_t;

  logic                    clk;
  logic                    rst;
  logic                    hdr_valid;
  logic                    hdr_ready;
  roce_pkg::udp_hdr_t      hdr;
  logic                    pay_valid;
  logic                    pay_ready;
  roce_pkg::payload_beat_t pay;
  logic                    ack_valid;
  logic                    ack_ready;
  roce_pkg::ack_rec_t      ack;
  roce_pkg::drop_t         drop;
  logic                    busy;

  row_t                    rows [NUM_ROWS];
  integer                  seed;
  int                      cycle_count = 0;

  roce_ack_rx #(
    .icrc_check_en (1'b1)
  ) dut (
    .clk       (clk),
    .rst       (rst),
    .hdr_valid (hdr_valid),
    .hdr_ready (hdr_ready),
    .hdr       (hdr),
    .pay_valid (pay_valid),
    .pay_ready (pay_ready),
    .pay       (pay),
    .ack_valid (ack_valid),
    .ack_ready (ack_ready),
    .ack       (ack),
    .drop      (drop),
    .busy      (busy)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout: the frame table did not finish within %0d cycles", MAX_CYCLES);
      $display("sim failed");
      $fatal(1, "run limit reached");
    end
  end

  // inputs change and outputs are read 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check(input logic [255:0] got, input logic [255:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR @ %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [roce_pkg::DATA_W-1:0] random_word();
    logic [roce_pkg::DATA_W-1:0] w;
    for (int i = 0; i < roce_pkg::DATA_W / 32; i++) begin
      w[32*i +: 32] = rand32();
    end
    return w;
  endfunction

  // big-endian field, most significant byte at the lowest byte index
  function automatic logic [roce_pkg::DATA_W-1:0] put_bytes(
    input logic [roce_pkg::DATA_W-1:0] w,
    input int                          first,
    input int                          count,
    input logic [31:0]                 value
  );
    logic [roce_pkg::DATA_W-1:0] r;
    r = w;
    for (int i = 0; i < count; i++) begin
      r[8*(first+i) +: 8] = value[8*(count-1-i) +: 8];
    end
    return r;
  endfunction

  function automatic row_t make_row(input logic [7:0] op, input logic [15:0] port,
                                    input logic icrc_match, input int beats,
                                    input int stalls, input logic [1:0] outcome);
    row_t r;
    r.op_code    = op;
    r.dest_port  = port;
    r.icrc_match = icrc_match;
    r.beats      = 2'(beats);
    r.stalls     = 4'(stalls);
    r.outcome    = outcome;
    return r;
  endfunction

  task automatic run_frame(input row_t r);
    roce_pkg::udp_hdr_t          h;
    roce_pkg::ack_rec_t          exp_ack;
    roce_pkg::drop_t             exp_drop;
    logic [roce_pkg::DATA_W-1:0] first;
    logic [31:0]                 rx_icrc;
    logic [31:0]                 rnd;
    int                          nbeats;
    int                          nstalls;

    nbeats  = int'(r.beats);
    nstalls = int'(r.stalls);

    h.ip_source_ip  = rand32();
    h.ip_dest_ip    = rand32();
    rnd             = rand32();
    h.udp_source_port = rnd[15:0];
    h.udp_dest_port = r.dest_port;
    h.udp_length    = 16'd36;
    h.computed_icrc = rand32();

    exp_ack.op_code  = r.op_code;
    rnd              = rand32();
    exp_ack.p_key    = rnd[15:0];
    rnd              = rand32();
    exp_ack.dest_qp  = rnd[23:0];
    exp_ack.ack_req  = rnd[31];
    rnd              = rand32();
    exp_ack.psn      = rnd[23:0];
    exp_ack.syndrome = rnd[31:24];
    rnd              = rand32();
    exp_ack.msn      = rnd[23:0];
    exp_ack.ip_source_ip    = h.ip_source_ip;
    exp_ack.ip_dest_ip      = h.ip_dest_ip;
    exp_ack.udp_source_port = h.udp_source_port;
    exp_ack.udp_dest_port   = h.udp_dest_port;

    rx_icrc = r.icrc_match ? h.computed_icrc : (h.computed_icrc ^ 32'h0001_0000);

    // reserved bytes keep random content
    first = random_word();
    first = put_bytes(first, 0, 1, 32'(exp_ack.op_code));
    first = put_bytes(first, 2, 2, 32'(exp_ack.p_key));
    first = put_bytes(first, 5, 3, 32'(exp_ack.dest_qp));
    first[71] = exp_ack.ack_req;
    first = put_bytes(first, 9, 3, 32'(exp_ack.psn));
    first = put_bytes(first, 12, 1, 32'(exp_ack.syndrome));
    first = put_bytes(first, 13, 3, 32'(exp_ack.msn));
    first = put_bytes(first, 16, 4, rx_icrc);

    exp_drop.not_ack  = (r.outcome == OUT_NOT_ACK);
    exp_drop.bad_icrc = (r.outcome == OUT_BAD_ICRC);

    // header
    hdr       = h;
    hdr_valid = 1'b1;
    while (!hdr_ready) next_cycle();
    next_cycle();
    hdr_valid = 1'b0;
    check(256'(busy), 256'(1'b1), "busy after header");
    check(256'(hdr_ready), 256'(1'b0), "hdr_ready during frame");
    check(256'(pay_ready), 256'(1'b1), "pay_ready after header");

    // payload, every beat read before any verdict
    for (int b = 0; b < nbeats; b++) begin
      pay.data  = (b == 0) ? first : random_word();
      pay.last  = (b == nbeats - 1);
      pay_valid = 1'b1;
      while (!pay_ready) next_cycle();
      check(256'(ack_valid), 256'(1'b0), "ack_valid before last beat");
      check(256'(busy), 256'(1'b1), "busy during payload");
      next_cycle();
    end
    pay_valid = 1'b0;
    pay       = '0;

    // decision cycle
    check(256'(ack_valid), 256'(1'b0), "ack_valid one cycle after last");
    check(256'(drop), 256'(2'b00), "drop one cycle after last");
    check(256'(busy), 256'(1'b1), "busy in decision cycle");
    check(256'(pay_ready), 256'(1'b0), "pay_ready after last beat");
    next_cycle();

    // two cycles after the last beat
    check(256'(drop), 256'(exp_drop), "drop reason");
    check(256'(busy), 256'(1'b0), "busy after decision");
    if (r.outcome == OUT_ACCEPT) begin
      check(256'(ack_valid), 256'(1'b1), "ack_valid two cycles after last");
      check(256'(ack), 256'(exp_ack), "ack record");
      check(256'(hdr_ready), 256'(1'b0), "hdr_ready with ack held");
      for (int s = 0; s < nstalls; s++) begin
        next_cycle();
        check(256'(ack_valid), 256'(1'b1), "ack_valid under stall");
        check(256'(ack), 256'(exp_ack), "ack record under stall");
        check(256'(hdr_ready), 256'(1'b0), "hdr_ready under stall");
        check(256'(drop), 256'(2'b00), "drop under stall");
      end
      ack_ready = 1'b1;
      next_cycle();
      ack_ready = 1'b0;
      check(256'(ack_valid), 256'(1'b0), "ack_valid after transfer");
      check(256'(hdr_ready), 256'(1'b1), "hdr_ready after ack transfer");
    end else begin
      check(256'(ack_valid), 256'(1'b0), "ack_valid on dropped frame");
      next_cycle();
      check(256'(drop), 256'(2'b00), "drop pulse length");
      check(256'(ack_valid), 256'(1'b0), "ack_valid after drop");
      check(256'(hdr_ready), 256'(1'b1), "hdr_ready after drop");
    end
    check(256'(busy), 256'(1'b0), "busy between frames");
  endtask

  initial begin
    seed      = 32'h66d4_e52e;
    rst       = 1'b1;
    hdr_valid = 1'b0;
    hdr       = '0;
    pay_valid = 1'b0;
    pay       = '0;
    ack_ready = 1'b0;

    //                 opcode    port        icrc  beats stalls outcome
    rows[0] = make_row(OP_ACK,   PORT_ROCE,  1'b1, 1,    0,     OUT_ACCEPT);
    rows[1] = make_row(OP_OTHER, PORT_ROCE,  1'b1, 1,    0,     OUT_NOT_ACK);
    rows[2] = make_row(OP_ACK,   PORT_OTHER, 1'b1, 1,    0,     OUT_NOT_ACK);
    rows[3] = make_row(OP_ACK,   PORT_ROCE,  1'b0, 1,    0,     OUT_BAD_ICRC);
    rows[4] = make_row(OP_ACK,   PORT_ROCE,  1'b1, 3,    5,     OUT_ACCEPT);
    rows[5] = make_row(OP_ACK,   PORT_ROCE,  1'b1, 2,    1,     OUT_ACCEPT);
    rows[6] = make_row(OP_OTHER, PORT_ROCE,  1'b0, 2,    0,     OUT_NOT_ACK);

    repeat (2) @(posedge clk);
    #1;
    check(256'(hdr_ready), 256'(1'b0), "hdr_ready in reset");
    check(256'(pay_ready), 256'(1'b0), "pay_ready in reset");
    check(256'(ack_valid), 256'(1'b0), "ack_valid in reset");
    check(256'(drop), 256'(2'b00), "drop in reset");
    check(256'(busy), 256'(1'b0), "busy in reset");
    rst = 1'b0;
    next_cycle();
    check(256'(hdr_ready), 256'(1'b1), "hdr_ready after reset");
    check(256'(busy), 256'(1'b0), "busy after reset");

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_frame(rows[i]);
    end

    $display("sim passed");
    $finish;
  end

endmodule

//--- testbench/roce_ack_rx_props.sv
/* handshake properties of the roce ack receiver, bound into the top level */
`timescale 1ns/1ps

module roce_ack_rx_props (
  input logic               clk,
  input logic               rst,
  input logic               hdr_ready,
  input logic               pay_ready,
  input logic               ack_valid,
  input logic               ack_ready,
  input roce_pkg::ack_rec_t ack
);

  // record holds while the consumer stalls
  ack_held: assert property (@(posedge clk) disable iff (rst)
    (ack_valid && !ack_ready) |=> $stable(ack))
    else $error("ack record changed while ack_valid was held");

  // no new header while a record waits
  hdr_blocked: assert property (@(posedge clk) disable iff (rst)
    !(hdr_ready && ack_valid))
    else $error("hdr_ready and ack_valid high together");

  one_input_open: assert property (@(posedge clk) disable iff (rst)
    !(hdr_ready && pay_ready))
    else $error("hdr_ready and pay_ready high together");

endmodule

bind roce_ack_rx roce_ack_rx_props u_props (
  .clk       (clk),
  .rst       (rst),
  .hdr_ready (hdr_ready),
  .pay_ready (pay_ready),
  .ack_valid (ack_valid),
  .ack_ready (ack_ready),
  .ack       (ack)
);

//--- rtl/roce_ack_rx.sv
/* roce v2 acknowledge receiver: takes a udp header and payload stream and
   hands out one acknowledge record per kept frame */
`timescale 1ns/1ps

module roce_ack_rx #(
  parameter bit icrc_check_en = 1'b1
) (
  input  logic                    clk,
  input  logic                    rst,

  // parsed udp/ip header
  input  logic                    hdr_valid,
  output logic                    hdr_ready,
  input  roce_pkg::udp_hdr_t      hdr,

  // payload stream
  input  logic                    pay_valid,
  output logic                    pay_ready,
  input  roce_pkg::payload_beat_t pay,

  // acknowledge record out
  output logic                    ack_valid,
  input  logic                    ack_ready,
  output roce_pkg::ack_rec_t      ack,

  // status
  output roce_pkg::drop_t         drop,
  output logic                    busy
);

  // controller strobes
  logic cap_hdr;
  logic cap_word;

  // parser verdict, registered
  logic frame_ok;
  logic frame_bad_icrc;

  roce_rx_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .hdr_valid      (hdr_valid),
    .pay_valid      (pay_valid),
    .pay_last       (pay.last),
    .ack_ready      (ack_ready),
    .frame_ok       (frame_ok),
    .frame_bad_icrc (frame_bad_icrc),
    .hdr_ready      (hdr_ready),
    .pay_ready      (pay_ready),
    .ack_valid      (ack_valid),
    .cap_hdr        (cap_hdr),
    .cap_word       (cap_word),
    .busy           (busy),
    .drop           (drop)
  );

  // only the first beat carries bth/aeth, the rest is drained
  roce_hdr_parse #(
    .icrc_check_en (icrc_check_en)
  ) u_parse (
    .clk            (clk),
    .cap_hdr        (cap_hdr),
    .cap_word       (cap_word),
    .hdr            (hdr),
    .word           (pay.data),
    .ack            (ack),
    .frame_ok       (frame_ok),
    .frame_bad_icrc (frame_bad_icrc)
  );

endmodule

//--- rtl/roce_hdr_parse.sv
/* header parser: holds the udp header, unpacks bth/aeth from the first beat
   and registers the opcode, port and icrc verdict */
`timescale 1ns/1ps

module roce_hdr_parse #(
  parameter bit icrc_check_en = 1'b1
) (
  input  logic                        clk,
  input  logic                        cap_hdr,
  input  logic                        cap_word,
  input  roce_pkg::udp_hdr_t          hdr,
  input  logic [roce_pkg::DATA_W-1:0] word,
  output roce_pkg::ack_rec_t          ack,
  output logic                        frame_ok,
  output logic                        frame_bad_icrc
);

  roce_pkg::ack_rec_t rec_q;
  logic [31:0]        computed_icrc_q;

  logic [31:0]        rx_icrc;
  logic               op_ok;
  logic               port_ok;
  logic               icrc_ok;

  // byte k sits at bits 8k+7:8k, multibyte fields are big-endian
  function automatic logic [7:0] byte_of(
    input logic [roce_pkg::DATA_W-1:0] w,
    input int unsigned                 k
  );
    return w[8*k +: 8];
  endfunction

  // icrc trails the aeth in an ack without payload
  assign rx_icrc = {byte_of(word, 16), byte_of(word, 17),
                    byte_of(word, 18), byte_of(word, 19)};

  // tests see the fresh beat against the header stored earlier
  assign op_ok   = (byte_of(word, 0) == roce_pkg::RC_RDMA_ACK);
  assign port_ok = (rec_q.udp_dest_port == roce_pkg::ROCE_UDP_PORT);
  assign icrc_ok = !icrc_check_en || (rx_icrc == computed_icrc_q);

  always_ff @(posedge clk) begin
    if (cap_hdr) begin
      rec_q.ip_source_ip    <= hdr.ip_source_ip;
      rec_q.ip_dest_ip      <= hdr.ip_dest_ip;
      rec_q.udp_source_port <= hdr.udp_source_port;
      rec_q.udp_dest_port   <= hdr.udp_dest_port;
      computed_icrc_q       <= hdr.computed_icrc;
    end

    if (cap_word) begin
      // bth
      rec_q.op_code  <= byte_of(word, 0);
      rec_q.p_key    <= {byte_of(word, 2), byte_of(word, 3)};
      rec_q.dest_qp  <= {byte_of(word, 5), byte_of(word, 6), byte_of(word, 7)};
      rec_q.ack_req  <= word[71];
      rec_q.psn      <= {byte_of(word, 9), byte_of(word, 10), byte_of(word, 11)};
      // aeth
      rec_q.syndrome <= byte_of(word, 12);
      rec_q.msn      <= {byte_of(word, 13), byte_of(word, 14), byte_of(word, 15)};

      // opcode or port failure outranks a bad icrc
      frame_ok       <= op_ok && port_ok && icrc_ok;
      frame_bad_icrc <= op_ok && port_ok && !icrc_ok;
    end
  end

  assign ack = rec_q;

endmodule

//--- rtl/roce_rx_ctrl.sv
/* frame sequencer: header and payload handshakes, capture strobes for the
   parser, held acknowledge valid and drop pulses */
`timescale 1ns/1ps

module roce_rx_ctrl (
  input  logic            clk,
  input  logic            rst,
  input  logic            hdr_valid,
  input  logic            pay_valid,
  input  logic            pay_last,
  input  logic            ack_ready,
  input  logic            frame_ok,
  input  logic            frame_bad_icrc,
  output logic            hdr_ready,
  output logic            pay_ready,
  output logic            ack_valid,
  output logic            cap_hdr,
  output logic            cap_word,
  output logic            busy,
  output roce_pkg::drop_t drop
);

  typedef enum logic [1:0] {
    S_IDLE   = 2'd0,
    S_FIRST  = 2'd1,
    S_DRAIN  = 2'd2,
    S_DECIDE = 2'd3
  } state_t;

  state_t          state_q;
  state_t          state_next;

  logic            hdr_ready_q;
  logic            hdr_ready_next;
  logic            pay_ready_q;
  logic            pay_ready_next;
  logic            ack_valid_q;
  logic            ack_valid_next;
  logic            busy_q;
  roce_pkg::drop_t drop_q;
  roce_pkg::drop_t drop_next;

  logic            hdr_xfer;
  logic            pay_xfer;
  logic            decide;

  assign hdr_xfer = hdr_valid && hdr_ready_q;
  assign pay_xfer = pay_valid && pay_ready_q;

  // parser verdict is consumed here, one cycle after the last beat
  assign decide = (state_q == S_DECIDE);

  always_comb begin
    state_next     = state_q;
    hdr_ready_next = 1'b0;
    pay_ready_next = 1'b0;
    ack_valid_next = ack_valid_q && !ack_ready;
    drop_next      = '0;
    cap_hdr        = 1'b0;
    cap_word       = 1'b0;

    case (state_q)
      S_IDLE: begin
        // next header waits until the held record has gone
        hdr_ready_next = !ack_valid_next;
        if (hdr_xfer) begin
          cap_hdr        = 1'b1;
          hdr_ready_next = 1'b0;
          pay_ready_next = 1'b1;
          state_next     = S_FIRST;
        end
      end

      S_FIRST: begin
        pay_ready_next = 1'b1;
        if (pay_xfer) begin
          cap_word = 1'b1;
          if (pay_last) begin
            pay_ready_next = 1'b0;
            state_next     = S_DECIDE;
          end else begin
            state_next = S_DRAIN;
          end
        end
      end

      S_DRAIN: begin
        // read and discard up to last
        pay_ready_next = 1'b1;
        if (pay_xfer && pay_last) begin
          pay_ready_next = 1'b0;
          state_next     = S_DECIDE;
        end
      end

      default: begin
        state_next = S_IDLE;
      end
    endcase

    if (decide) begin
      ack_valid_next     = frame_ok;
      drop_next.not_ack  = !frame_ok && !frame_bad_icrc;
      drop_next.bad_icrc = frame_bad_icrc;
      // a dropped frame frees the input right away
      hdr_ready_next     = !frame_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= S_IDLE;
      hdr_ready_q <= 1'b0;
      pay_ready_q <= 1'b0;
      ack_valid_q <= 1'b0;
      drop_q      <= '0;
      busy_q      <= 1'b0;
    end else begin
      state_q     <= state_next;
      hdr_ready_q <= hdr_ready_next;
      pay_ready_q <= pay_ready_next;
      ack_valid_q <= ack_valid_next;
      drop_q      <= drop_next;
      busy_q      <= (state_next != S_IDLE);
    end
  end

  assign hdr_ready = hdr_ready_q;
  assign pay_ready = pay_ready_q;
  assign ack_valid = ack_valid_q;
  assign drop      = drop_q;
  assign busy      = busy_q;

endmodule

//--- rtl/roce_pkg.sv
/* roce ack receive path: shared constants and the header, beat and record types
   used between the controller, the parser and the top level */
package roce_pkg;

  // payload beat width
  localparam int DATA_W = 512;

  // RoCE v2 well-known destination port
  localparam logic [15:0] ROCE_UDP_PORT = 16'd4791;

  // RC acknowledge opcode
  localparam logic [7:0] RC_RDMA_ACK = 8'h11;

  // parsed udp/ip header, computed icrc comes from the upstream crc engine
  typedef struct packed {
    logic [31:0] ip_source_ip;
    logic [31:0] ip_dest_ip;
    logic [15:0] udp_source_port;
    logic [15:0] udp_dest_port;
    logic [15:0] udp_length;
    logic [31:0] computed_icrc;
  } udp_hdr_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } payload_beat_t;

  // acknowledge record handed downstream
  typedef struct packed {
    // bth
    logic [7:0]  op_code;
    logic [15:0] p_key;
    logic [23:0] dest_qp;
    logic        ack_req;
    logic [23:0] psn;
    // aeth
    logic [7:0]  syndrome;
    logic [23:0] msn;
    // pass-through from the udp header
    logic [31:0] ip_source_ip;
    logic [31:0] ip_dest_ip;
    logic [15:0] udp_source_port;
    logic [15:0] udp_dest_port;
  } ack_rec_t;

  // drop reasons, each a one-cycle pulse
  typedef struct packed {
    logic not_ack;
    logic bad_icrc;
  } drop_t;

endpackage
